// File: Bender.yml
package:
  name: long_exec

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/exu_pkg.sv
      - verilog/sb_pkg.sv
      - verilog/exu_if.sv
      - verilog/hazard_unit.sv
      - verilog/mul_unit.sv
      - verilog/div_unit.sv
      - verilog/commit_arb.sv
      - verilog/long_exec_top.sv
  - target: simulation
    files:
      - sim/long_exec_chk.sv
      - sim/long_exec_tb.sv

// File: filelist.f
+incdir+verilog
verilog/exu_pkg.sv
verilog/sb_pkg.sv
verilog/exu_if.sv
verilog/hazard_unit.sv
verilog/mul_unit.sv
verilog/div_unit.sv
verilog/commit_arb.sv
verilog/long_exec_top.sv
sim/long_exec_chk.sv
sim/long_exec_tb.sv

// File: sim/long_exec_chk.sv
// scoreboard assertions
`timescale 1ns/1ps
`default_nettype none

`include "lx_macros.svh"

module long_exec_chk (
    input wire                     clk,
    input wire                     rst_n,
    input wire                     stall_o,
    input wire                     accept_o,
    input sb_pkg::sb_id_t          alloc_id_o,
    input wire                     commit_valid_i,
    input sb_pkg::sb_id_t          commit_id_i,
    input wire [`LX_REG_AW-1:0]    commit_rd_i,
    input wire [`LX_SB_DEPTH-1:0]  slot_valid,
    input wire [`LX_REG_AW-1:0]    slot_rd        // stored rd of the committing slot
);
    import sb_pkg::*;

    int fail_cnt = 0;   // assertion failures so far

    // a stalled instruction never sets a slot bit at the next edge
    a_stall_blocks: assert property (@(posedge clk) disable iff (!rst_n)
        stall_o |=> ((slot_valid & ~$past(slot_valid)) == '0))
        else begin
            fail_cnt++;
            $error("slot allocated while stall is high");
        end

    a_commit_live: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid_i |-> slot_valid[commit_id_i])
        else begin
            fail_cnt++;
            $error("commit to a slot that is not valid");
        end

    // writeback must target what was recorded at issue
    a_commit_rd: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid_i |-> (commit_rd_i == slot_rd))
        else begin
            fail_cnt++;
            $error("commit rd differs from stored rd");
        end

    // accepted only into a free slot, so never with all slots taken
    a_alloc_free: assert property (@(posedge clk) disable iff (!rst_n)
        accept_o |-> !slot_valid[alloc_id_o])
        else begin
            fail_cnt++;
            $error("accept into a slot that is already valid");
        end

endmodule

bind hazard_unit long_exec_chk u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .stall_o        (stall_o),
    .accept_o       (accept_o),
    .alloc_id_o     (alloc_id_o),
    .commit_valid_i (commit_valid_i),
    .commit_id_i    (commit_id_i),
    .commit_rd_i    (commit_rd_i),
    .slot_valid     (slot_valid),
    .slot_rd        (slot_q[commit_id_i].rd)
);

`default_nettype wire

// File: sim/long_exec_tb.sv
// long execution back end testbench
`timescale 1ns/1ps
`default_nettype none

`include "lx_macros.svh"

module long_exec_tb;
    import exu_pkg::*;
    import sb_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NROWS      = 17;
    localparam int DEPTH      = `LX_SB_DEPTH;

    typedef struct {
        exu_op_e     op;
        logic [4:0]  rd, rs1, rs2;
        bit          re1, re2;
        logic [31:0] a, b;
        bit          rnd;        // operands from the lcg
        int          gap;        // idle cycles before the row
        bit          exp_stall;  // stall on first presentation
    } row_t;

    logic clk = 1'b0;
    logic rst_n;
    logic issue_valid_i, issue_rs1_re_i, issue_rs2_re_i;
    exu_op_e issue_op_i;
    logic [`LX_REG_AW-1:0] issue_rd_i, issue_rs1_i, issue_rs2_i, wb_rd_o;
    logic [`LX_XLEN-1:0] issue_a_i, issue_b_i, wb_data_o;
    logic issue_stall_o, wb_valid_o, pending_o;
    sb_id_t issue_id_o, wb_id_o;

    row_t tbl[$];
    // reference scoreboard with one entry per slot id
    bit          m_vld [DEPTH];
    bit          m_div [DEPTH];
    logic [4:0]  m_rd  [DEPTH];
    logic [31:0] m_data[DEPTH];
    int          m_acc [DEPTH];       // cycle of the accepting edge
    bit          c_now, c_div;        // writeback seen this cycle
    sb_id_t      c_id;
    int cyc = 0, errors = 0, checks = 0;
    logic [31:0] lcg_state = 32'd17;

    long_exec_top uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic bit is_div(exu_op_e op);
        return op == OP_DIVU || op == OP_REMU;
    endfunction

    // riscv unsigned results including divide by zero
    function automatic logic [31:0] golden(exu_op_e op, logic [31:0] a, logic [31:0] b);
        logic [63:0] p;
        p = {32'b0, a} * {32'b0, b};
        case (op)
            OP_MUL:   return p[31:0];
            OP_MULHU: return p[63:32];
            OP_DIVU:  return (b == 0) ? 32'hffff_ffff : a / b;
            default:  return (b == 0) ? a : a % b;
        endcase
    endfunction

    // expected stall with the committing slot already removed
    function automatic bit model_stall(row_t r);
        bit hz;
        int cnt;
        hz  = 1'b0;
        cnt = c_now;
        for (int i = 0; i < DEPTH; i++) begin
            if (m_vld[i]) begin
                cnt++;
                if (m_rd[i] != 0 && ((r.re1 && r.rs1 == m_rd[i]) || (r.re2 && r.rs2 == m_rd[i])))
                    hz = 1'b1;   // raw
                if (r.rd != 0 && r.rd == m_rd[i] && m_div[i] != is_div(r.op))
                    hz = 1'b1;   // waw across units
                if (m_div[i] && is_div(r.op))
                    hz = 1'b1;   // divider busy
            end
        end
        if (c_now && c_div && is_div(r.op))
            hz = 1'b1;           // divider still in done
        return hz || (cnt == DEPTH);
    endfunction

    function automatic int model_free_id();
        for (int i = 0; i < DEPTH; i++)
            if (!m_vld[i] && !(c_now && c_id == sb_id_t'(i))) return i;
        return 0;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic fail_note(string what);
        errors++;
        $display("%s", what);
    endtask

    // wait for the falling edge and retire any writeback into the model
    task automatic tick();
        int lat;
        @(negedge clk);
        c_now = 1'b0;
        c_div = 1'b0;
        if (wb_valid_o) begin
            c_now = 1'b1;
            c_id  = wb_id_o;
            if (!m_vld[wb_id_o]) begin
                fail_note($sformatf("writeback for slot %0d that is not in flight", wb_id_o));
            end else begin
                c_div = m_div[wb_id_o];
                lat   = cyc + 1 - m_acc[wb_id_o];   // commit edge minus accepting edge
                check_val("wb_rd_o", wb_rd_o, m_rd[wb_id_o]);
                check_val("wb_data_o", wb_data_o, m_data[wb_id_o]);
                checks++;
                if (!c_div && lat != 3) begin
                    fail_note($sformatf("multiply in slot %0d wrote back after %0d cycles",
                                        wb_id_o, lat));
                end
                if (c_div && lat < 34) begin
                    fail_note($sformatf("divide in slot %0d finished after only %0d cycles",
                                        wb_id_o, lat));
                end
                m_vld[wb_id_o] = 1'b0;
            end
        end
    endtask

    task automatic add(exu_op_e op, int rd, int rs1, int rs2, bit re1, bit re2,
                       logic [31:0] a, logic [31:0] b, bit rnd, int gap, bit st);
        tbl.push_back('{op, rd, rs1, rs2, re1, re2, a, b, rnd, gap, st});
    endtask

    initial begin
        #(NROWS * 40 * CLK_PERIOD);
        $display("timeout: the run did not finish within the time budget");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        row_t r;
        bit   done, first;
        int   stalls, id;
        issue_valid_i = 0;
        issue_op_i = OP_MUL;
        issue_rd_i = 0;
        issue_rs1_i = 0;
        issue_rs2_i = 0;
        issue_rs1_re_i = 0;
        issue_rs2_re_i = 0;
        issue_a_i = 0;
        issue_b_i = 0;
        rst_n = 1'b0;
        add(OP_MUL,    1,  0,  0, 0, 0, 32'd3, 32'd5, 0, 0, 0);
        add(OP_MULHU,  1,  0,  0, 0, 0, 32'hffff_ffff, 32'hffff_ffff, 0, 0, 0);  // row 0 in flight
        add(OP_MUL,    1,  0,  0, 0, 0, 0, 0, 1, 0, 0);   // same rd again on the same unit
        add(OP_DIVU,   3,  0,  0, 0, 0, 32'd100, 32'd7, 0, 0, 0);
        add(OP_REMU,   4,  0,  0, 0, 0, 32'd100, 32'd7, 0, 0, 1);  // divider busy
        add(OP_MUL,    4,  0,  0, 0, 0, 0, 0, 1, 0, 1);   // waw on pending remu
        add(OP_MUL,    5,  4,  0, 1, 0, 0, 0, 1, 0, 1);   // raw on mul
        add(OP_DIVU,   6,  0,  0, 0, 0, 32'hdead_beef, 32'd0, 0, 0, 0);
        add(OP_REMU,   7,  0,  0, 0, 0, 32'd12345, 32'd0, 0, 0, 1);
        add(OP_MUL,    8,  7,  0, 1, 0, 0, 0, 1, 0, 1);   // raw on divide
        add(OP_DIVU,   9,  0,  0, 0, 0, 0, 0, 1, 0, 0);
        add(OP_MUL,   10,  0,  0, 0, 0, 0, 0, 1, 29, 0);  // lands with the divide
        add(OP_MUL,   11,  9, 10, 1, 1, 0, 0, 1, 0, 1);
        add(OP_MUL,    0,  0,  0, 0, 0, 0, 0, 1, 0, 0);   // writes x0
        add(OP_MULHU, 12,  0,  0, 1, 1, 0, 0, 1, 0, 0);   // reads x0 with an x0 write pending
        add(OP_DIVU,  13, 11,  0, 1, 0, 0, 0, 1, 0, 0);
        add(OP_DIVU,  14,  0,  0, 0, 0, 0, 0, 1, 0, 1);
        repeat (3) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;
        foreach (tbl[n]) begin
            r = tbl[n];
            repeat (r.gap) begin
                tick();
                issue_valid_i = 1'b0;
            end
            if (r.rnd) begin
                r.a = lcg_next();
                r.b = lcg_next();
            end
            done = 0;
            first = 1;
            stalls = 0;
            while (!done) begin
                tick();
                issue_valid_i = 1'b1;
                issue_op_i = r.op;
                issue_rd_i = r.rd;
                issue_rs1_i = r.rs1;
                issue_rs2_i = r.rs2;
                issue_rs1_re_i = r.re1;
                issue_rs2_re_i = r.re2;
                issue_a_i = r.a;
                issue_b_i = r.b;
                #1;
                check_val("issue_stall_o", issue_stall_o, model_stall(r));
                if (first && issue_stall_o !== r.exp_stall)
                    fail_note($sformatf("row %0d stall on first cycle disagrees with table", n));
                first = 0;
                if (!issue_stall_o) begin
                    id = model_free_id();
                    check_val("issue_id_o", issue_id_o, id);
                    m_vld[id] = 1;
                    m_div[id] = is_div(r.op);
                    m_rd[id] = r.rd;
                    m_data[id] = golden(r.op, r.a, r.b);
                    m_acc[id] = cyc + 1;
                    done = 1;
                end else begin
                    stalls++;
                end
            end
            $display("row %0d %s rd x%0d: id %0d after %0d stall cycles",
                     n, r.op.name(), r.rd, id, stalls);
            tick();
            issue_valid_i = 1'b0;
            #1 check_val("pending_o", pending_o, 1);   // just accepted
        end
        while (c_now || m_vld.or() != 0) tick();
        #1 check_val("pending_o", pending_o, 0);
        repeat (5) tick();   // no stray writebacks
        errors += uut.u_hazard.u_chk.fail_cnt;
        $display("rows %0d, checks %0d, errors %0d", tbl.size(), checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/commit_arb.sv
// writeback commit arbiter
`timescale 1ns/1ps
`default_nettype none

`include "lx_macros.svh"

module commit_arb (
    exu_if.ctrl                    mul_bus,
    exu_if.ctrl                    div_bus,
    output logic                   commit_valid_o,
    output sb_pkg::sb_id_t         commit_id_o,
    output logic [`LX_REG_AW-1:0]  commit_rd_o,
    output logic [`LX_XLEN-1:0]    commit_data_o
);

    logic mul_gnt;
    logic div_gnt;

    // multiplier cannot stall, so it always wins
    assign mul_gnt = mul_bus.res_valid;
    assign div_gnt = div_bus.res_valid && !mul_bus.res_valid;  // divider waits

    assign mul_bus.res_ack = mul_gnt;
    assign div_bus.res_ack = div_gnt;

    assign commit_valid_o = mul_gnt || div_gnt;

    // and-or mux, loser fields masked to zero
    assign commit_id_o   = (mul_bus.res_id & {$bits(commit_id_o){mul_gnt}}) |
                           (div_bus.res_id & {$bits(commit_id_o){div_gnt}});
    assign commit_rd_o   = (mul_bus.res_rd & {`LX_REG_AW{mul_gnt}}) |
                           (div_bus.res_rd & {`LX_REG_AW{div_gnt}});
    assign commit_data_o = (mul_bus.res_data & {`LX_XLEN{mul_gnt}}) |
                           (div_bus.res_data & {`LX_XLEN{div_gnt}});

endmodule

`default_nettype wire

// File: verilog/div_unit.sv
// iterative unsigned divider
`timescale 1ns/1ps
`default_nettype none

`include "lx_macros.svh"

module div_unit (
    input  wire   clk,
    input  wire   rst_n,
    exu_if.unit   bus
);
    import exu_pkg::*;
    import sb_pkg::*;

    localparam int CW = $clog2(`LX_XLEN) + 1;

    div_state_e             state_q;
    logic [CW-1:0]          cnt_q;        // step count, last value finishes
    logic [`LX_XLEN-1:0]    quo_q;        // dividend shifts out, quotient in
    logic [`LX_XLEN-1:0]    rem_q;
    logic [`LX_XLEN-1:0]    dvs_q;        // divisor
    logic [`LX_XLEN-1:0]    res_q;
    exu_op_e                op_q;
    sb_id_t                 id_q;
    logic [`LX_REG_AW-1:0]  rd_q;

    logic [`LX_XLEN:0]      rem_sh;       // partial remainder with next bit
    logic [`LX_XLEN:0]      rem_sub;
    logic                   step_ge;      // subtract fits

    assign rem_sh  = {rem_q, quo_q[`LX_XLEN-1]};
    assign rem_sub = rem_sh - {1'b0, dvs_q};
    assign step_ge = (rem_sh >= {1'b0, dvs_q});

    // fsm
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: if (bus.issue_fire) begin
                    state_q <= DIV_RUN;
                    cnt_q   <= '0;
                end
                DIV_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CW'(`LX_XLEN)) state_q <= DIV_DONE;  // result latched
                end
                DIV_DONE: if (bus.res_ack) state_q <= DIV_IDLE;      // held until taken
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    // datapath, divisor 0 gives all-ones quotient and dividend remainder by itself
    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && bus.issue_fire) begin
            quo_q <= bus.a;
            rem_q <= '0;
            dvs_q <= bus.b;
            op_q  <= bus.op;
            id_q  <= bus.id;
            rd_q  <= bus.rd;
        end else if (state_q == DIV_RUN) begin
            if (cnt_q < CW'(`LX_XLEN)) begin
                rem_q <= step_ge ? rem_sub[`LX_XLEN-1:0] : rem_sh[`LX_XLEN-1:0];
                quo_q <= {quo_q[`LX_XLEN-2:0], step_ge};
            end else begin
                res_q <= (op_q == OP_REMU) ? rem_q : quo_q;
            end
        end
    end

    assign bus.ready     = (state_q == DIV_IDLE);
    assign bus.res_valid = (state_q == DIV_DONE);
    assign bus.res_id    = id_q;
    assign bus.res_rd    = rd_q;
    assign bus.res_data  = res_q;

endmodule

`default_nettype wire

// File: verilog/exu_if.sv
// execution unit issue and result bus
`timescale 1ns/1ps
`default_nettype none

`include "lx_macros.svh"

interface exu_if;
    import exu_pkg::*;
    import sb_pkg::*;

    // issue side
    logic                  issue_fire;  // one cycle per accepted instruction
    exu_op_e               op;
    sb_id_t                id;
    logic [`LX_REG_AW-1:0] rd;
    logic [`LX_XLEN-1:0]   a;
    logic [`LX_XLEN-1:0]   b;
    logic                  ready;       // unit can take a new instruction

    // result side, held until res_ack
    logic                  res_valid;
    sb_id_t                res_id;
    logic [`LX_REG_AW-1:0] res_rd;
    logic [`LX_XLEN-1:0]   res_data;
    logic                  res_ack;

    modport ctrl (
        output issue_fire, op, id, rd, a, b, res_ack,
        input  ready, res_valid, res_id, res_rd, res_data
    );

    modport unit (
        input  issue_fire, op, id, rd, a, b, res_ack,
        output ready, res_valid, res_id, res_rd, res_data
    );

endinterface

`default_nettype wire

// File: verilog/exu_pkg.sv
// execution unit enums
`default_nettype none

package exu_pkg;

    // long-latency opcodes, unsigned only
    typedef enum logic [1:0] {
        OP_MUL   = 2'd0,  // low product
        OP_MULHU = 2'd1,  // high product
        OP_DIVU  = 2'd2,
        OP_REMU  = 2'd3
    } exu_op_e;

    typedef enum logic {
        UNIT_MUL = 1'b0,
        UNIT_DIV = 1'b1
    } exu_unit_e;

    // divider fsm
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } div_state_e;

    // opcode to owning unit
    function automatic exu_unit_e unit_of(exu_op_e op);
        return (op == OP_DIVU || op == OP_REMU) ? UNIT_DIV : UNIT_MUL;
    endfunction

endpackage

`default_nettype wire

// File: verilog/hazard_unit.sv
// scoreboard hazard unit
`timescale 1ns/1ps
`default_nettype none

`include "lx_macros.svh"

module hazard_unit (
    input  wire                    clk,
    input  wire                    rst_n,

    // dispatch
    input  wire                    inst_valid_i,
    input  exu_pkg::exu_op_e       op_i,
    input  wire [`LX_REG_AW-1:0]   rd_i,
    input  wire [`LX_REG_AW-1:0]   rs1_i,
    input  wire [`LX_REG_AW-1:0]   rs2_i,
    input  wire                    rs1_re_i,
    input  wire                    rs2_re_i,
    input  wire                    div_ready_i,   // divider idle

    // commit, frees a slot
    input  wire                    commit_valid_i,
    input  sb_pkg::sb_id_t         commit_id_i,
    input  wire [`LX_REG_AW-1:0]   commit_rd_i,   // checked by the bound assertions

    output logic                   stall_o,
    output logic                   accept_o,
    output sb_pkg::sb_id_t         alloc_id_o,
    output logic                   pending_o
);
    import exu_pkg::*;
    import sb_pkg::*;

    localparam int DEPTH = `LX_SB_DEPTH;

    logic [DEPTH-1:0] slot_valid;          // slot in flight
    sb_entry_t        slot_q [DEPTH];      // rd and owner per slot

    exu_unit_e        new_unit;
    logic [DEPTH-1:0] commit_hit;          // slot retiring this cycle
    logic [DEPTH-1:0] raw_vec;
    logic [DEPTH-1:0] waw_vec;
    logic             raw_hazard;
    logic             waw_hazard;
    logic             sb_full;
    logic             div_busy;
    sb_id_t           free_id;

    assign new_unit = unit_of(op_i);

    // per-slot compare
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            commit_hit[i] = commit_valid_i && (commit_id_i == sb_id_t'(i));
            // rd x0 in a slot is no write, never a producer
            raw_vec[i] = slot_valid[i] && !commit_hit[i] && (slot_q[i].rd != '0) &&
                         ((rs1_re_i && rs1_i == slot_q[i].rd) ||
                          (rs2_re_i && rs2_i == slot_q[i].rd));
            // same unit writes back in order, other unit may overtake
            waw_vec[i] = slot_valid[i] && !commit_hit[i] && (rd_i != '0) &&
                         (rd_i == slot_q[i].rd) && (slot_q[i].unit != new_unit);
        end
    end

    assign raw_hazard = |raw_vec;
    assign waw_hazard = |waw_vec;
    assign sb_full    = &slot_valid;     // a committing slot is not reused this cycle
    assign div_busy   = (new_unit == UNIT_DIV) && !div_ready_i;

    assign stall_o  = inst_valid_i && (raw_hazard || waw_hazard || sb_full || div_busy);
    assign accept_o = inst_valid_i && !stall_o;

    // lowest free slot wins, scan from the top
    always_comb begin
        free_id = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_id = sb_id_t'(i);
            end
        end
    end

    assign alloc_id_o = free_id;
    assign pending_o  = |slot_valid;

    // valid bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= '0;
        end else begin
            if (commit_valid_i) begin
                slot_valid[commit_id_i] <= 1'b0;   // retire
            end
            if (accept_o) begin
                slot_valid[free_id] <= 1'b1;       // never the retiring slot
            end
        end
    end

    // slot payload
    always_ff @(posedge clk) begin
        if (accept_o) begin
            slot_q[free_id].rd   <= rd_i;
            slot_q[free_id].unit <= new_unit;
        end
    end

endmodule

`default_nettype wire

// File: verilog/long_exec_top.sv
// long-latency execution back end
`timescale 1ns/1ps
`default_nettype none

`include "lx_macros.svh"

module long_exec_top (
    input  wire                    clk,
    input  wire                    rst_n,

    // dispatch
    input  wire                    issue_valid_i,
    input  exu_pkg::exu_op_e       issue_op_i,
    input  wire [`LX_REG_AW-1:0]   issue_rd_i,
    input  wire [`LX_REG_AW-1:0]   issue_rs1_i,
    input  wire [`LX_REG_AW-1:0]   issue_rs2_i,
    input  wire                    issue_rs1_re_i,
    input  wire                    issue_rs2_re_i,
    input  wire [`LX_XLEN-1:0]     issue_a_i,
    input  wire [`LX_XLEN-1:0]     issue_b_i,
    output logic                   issue_stall_o,
    output sb_pkg::sb_id_t         issue_id_o,     // slot of the accepted instruction

    // writeback, one per cycle
    output logic                   wb_valid_o,
    output sb_pkg::sb_id_t         wb_id_o,
    output logic [`LX_REG_AW-1:0]  wb_rd_o,
    output logic [`LX_XLEN-1:0]    wb_data_o,
    output logic                   pending_o
);
    import exu_pkg::*;

    logic      accept;
    exu_unit_e issue_unit;

    exu_if mul_bus ();
    exu_if div_bus ();

    assign issue_unit = unit_of(issue_op_i);

    hazard_unit u_hazard (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid_i   (issue_valid_i),
        .op_i           (issue_op_i),
        .rd_i           (issue_rd_i),
        .rs1_i          (issue_rs1_i),
        .rs2_i          (issue_rs2_i),
        .rs1_re_i       (issue_rs1_re_i),
        .rs2_re_i       (issue_rs2_re_i),
        .div_ready_i    (div_bus.ready),
        .commit_valid_i (wb_valid_o),
        .commit_id_i    (wb_id_o),
        .commit_rd_i    (wb_rd_o),
        .stall_o        (issue_stall_o),
        .accept_o       (accept),
        .alloc_id_o     (issue_id_o),
        .pending_o      (pending_o)
    );

    // fire only the unit that owns the opcode
    assign mul_bus.issue_fire = accept && (issue_unit == UNIT_MUL);
    assign div_bus.issue_fire = accept && (issue_unit == UNIT_DIV);

    // fields fan out to both units
    assign mul_bus.op = issue_op_i;
    assign mul_bus.id = issue_id_o;
    assign mul_bus.rd = issue_rd_i;
    assign mul_bus.a  = issue_a_i;
    assign mul_bus.b  = issue_b_i;
    assign div_bus.op = issue_op_i;
    assign div_bus.id = issue_id_o;
    assign div_bus.rd = issue_rd_i;
    assign div_bus.a  = issue_a_i;
    assign div_bus.b  = issue_b_i;

    mul_unit u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (mul_bus)
    );

    div_unit u_div (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (div_bus)
    );

    commit_arb u_arb (
        .mul_bus        (mul_bus),
        .div_bus        (div_bus),
        .commit_valid_o (wb_valid_o),
        .commit_id_o    (wb_id_o),
        .commit_rd_o    (wb_rd_o),
        .commit_data_o  (wb_data_o)
    );

endmodule

`default_nettype wire

// File: verilog/lx_macros.svh
// long-latency execution widths
`ifndef LX_MACROS_SVH
`define LX_MACROS_SVH

`default_nettype none

// data path width, rv32
`define LX_XLEN 32

// register address width, x0..x31
`define LX_REG_AW 5

`define LX_SB_DEPTH 8    // scoreboard slots
`define LX_MUL_STAGES 3  // multiplier latency in cycles

`default_nettype wire

`endif

// File: verilog/mul_unit.sv
// pipelined unsigned multiplier
`timescale 1ns/1ps
`default_nettype none

`include "lx_macros.svh"

module mul_unit (
    input  wire   clk,
    input  wire   rst_n,
    exu_if.unit   bus
);
    import exu_pkg::*;
    import sb_pkg::*;

    // stage 1 operands, stage 2 full product, stage 3 selected half
    logic                     s1_vld_q, s2_vld_q, s3_vld_q;
    logic [`LX_XLEN-1:0]      s1_a_q, s1_b_q;
    logic                     s1_hi_q, s2_hi_q;     // mulhu wants the upper word
    sb_id_t                   s1_id_q, s2_id_q, s3_id_q;
    logic [`LX_REG_AW-1:0]    s1_rd_q, s2_rd_q, s3_rd_q;
    logic [2*`LX_XLEN-1:0]    s2_prod_q;
    logic [`LX_XLEN-1:0]      s3_data_q;

    assign bus.ready = 1'b1;  // fully pipelined, no back-pressure

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld_q <= 1'b0;
            s2_vld_q <= 1'b0;
            s3_vld_q <= 1'b0;
        end else begin
            s1_vld_q <= bus.issue_fire;
            s2_vld_q <= s1_vld_q;
            s3_vld_q <= s2_vld_q;
        end
    end

    always_ff @(posedge clk) begin
        s1_a_q    <= bus.a;
        s1_b_q    <= bus.b;
        s1_hi_q   <= (bus.op == OP_MULHU);
        s1_id_q   <= bus.id;
        s1_rd_q   <= bus.rd;
        s2_prod_q <= s1_a_q * s1_b_q;   // 64-bit context, zero extended
        s2_hi_q   <= s1_hi_q;
        s2_id_q   <= s1_id_q;
        s2_rd_q   <= s1_rd_q;
        s3_data_q <= s2_hi_q ? s2_prod_q[2*`LX_XLEN-1:`LX_XLEN] : s2_prod_q[`LX_XLEN-1:0];
        s3_id_q   <= s2_id_q;
        s3_rd_q   <= s2_rd_q;
    end

    // arbiter always grants us, res_ack not needed
    assign bus.res_valid = s3_vld_q;
    assign bus.res_id    = s3_id_q;
    assign bus.res_rd    = s3_rd_q;
    assign bus.res_data  = s3_data_q;

endmodule

`default_nettype wire

// File: verilog/sb_pkg.sv
// scoreboard types
`default_nettype none

`include "lx_macros.svh"

package sb_pkg;

    // slot id, one per scoreboard entry
    typedef logic [$clog2(`LX_SB_DEPTH)-1:0] sb_id_t;

    // per-slot record, valid bit kept outside
    typedef struct packed {
        logic [`LX_REG_AW-1:0] rd;    // destination, 0 means no write
        exu_pkg::exu_unit_e    unit;  // unit that owns the result
    } sb_entry_t;

endpackage

`default_nettype wire
